// File: verilog/axi3_pkg.sv
package axi3_pkg;

    // per-channel stage behaviour.
    typedef enum logic [1:0] {
        SLICE_BYPASS  = 2'd0,
        SLICE_FORWARD = 2'd1,
        SLICE_REVERSE = 2'd2,
        SLICE_FULL    = 2'd3
    } reg_slice_config_t;

    // fixed AXI3 field widths.
    localparam int AXI3_LEN_WID    = 4;
    localparam int AXI3_SIZE_WID   = 3;
    localparam int AXI3_BURST_WID  = 2;
    localparam int AXI3_LOCK_WID   = 2;
    localparam int AXI3_CACHE_WID  = 4;
    localparam int AXI3_PROT_WID   = 3;
    localparam int AXI3_QOS_WID    = 4;
    localparam int AXI3_REGION_WID = 4;
    localparam int AXI3_RESP_WID   = 2;

    // response codes.
    localparam logic [AXI3_RESP_WID-1:0] AXI3_RESP_OKAY   = 2'b00;
    localparam logic [AXI3_RESP_WID-1:0] AXI3_RESP_SLVERR = 2'b10;

    // registered modes hold the peripheral in reset one edge longer.
    function automatic int reset_pipe_stages(input reg_slice_config_t cfg);
        case (cfg)
            SLICE_BYPASS,
            SLICE_REVERSE: return 0;
            default:       return 1;
        endcase
    endfunction

endpackage : axi3_pkg

// File: verilog/axi_channel_slice.sv
`timescale 1ns/1ps

module axi_channel_slice
    import axi3_pkg::*;
#(
    parameter int                PAYLOAD_WID = 8,
    parameter reg_slice_config_t CONFIG      = SLICE_FULL
) (
    input  logic                   aclk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  logic [PAYLOAD_WID-1:0] in_data,
    output logic                   out_valid,
    input  logic                   out_ready,
    output logic [PAYLOAD_WID-1:0] out_data
);

    generate
        if (CONFIG == SLICE_BYPASS) begin : g_bypass
            assign out_valid = in_valid;
            assign out_data  = in_data;
            assign in_ready  = out_ready;

        end else if (CONFIG == SLICE_FORWARD) begin : g_forward
            logic                   valid_q;
            logic [PAYLOAD_WID-1:0] data_q;

            // accept when the output register drains or is empty.
            assign in_ready  = out_ready || !valid_q;
            assign out_valid = valid_q;
            assign out_data  = data_q;

            always_ff @(posedge aclk or negedge rst_n) begin
                if (!rst_n) begin
                    valid_q <= 1'b0;
                end else if (in_ready) begin
                    valid_q <= in_valid;
                end
            end

            always_ff @(posedge aclk) begin
                if (in_ready && in_valid) begin
                    data_q <= in_data;
                end
            end

        end else if (CONFIG == SLICE_REVERSE) begin : g_reverse
            logic                   ready_q;
            logic [PAYLOAD_WID-1:0] skid_q;

            // low ready means the skid register holds a beat.
            assign in_ready  = ready_q;
            assign out_valid = in_valid || !ready_q;
            assign out_data  = ready_q ? in_data : skid_q;

            always_ff @(posedge aclk or negedge rst_n) begin
                if (!rst_n) begin
                    ready_q <= 1'b1;
                end else if (!ready_q) begin
                    if (out_ready) begin
                        ready_q <= 1'b1;
                    end
                end else if (in_valid && !out_ready) begin
                    ready_q <= 1'b0;
                end
            end

            always_ff @(posedge aclk) begin
                if (ready_q && in_valid && !out_ready) begin
                    skid_q <= in_data;
                end
            end

        end else begin : g_full
            logic [1:0]             count_q;
            logic [1:0]             count_d;
            logic                   valid_q;
            logic                   ready_q;
            logic [PAYLOAD_WID-1:0] main_q;
            logic [PAYLOAD_WID-1:0] skid_q;
            logic                   push;
            logic                   pop;

            assign in_ready  = ready_q;
            assign out_valid = valid_q;
            assign out_data  = main_q;

            assign push = in_valid && ready_q;
            assign pop  = valid_q && out_ready;

            always_comb begin
                case ({push, pop})
                    2'b10:   count_d = count_q + 2'd1;
                    2'b01:   count_d = count_q - 2'd1;
                    default: count_d = count_q;
                endcase
            end

            // valid and ready come straight from flops.
            always_ff @(posedge aclk or negedge rst_n) begin
                if (!rst_n) begin
                    count_q <= 2'd0;
                    valid_q <= 1'b0;
                    ready_q <= 1'b1;
                end else begin
                    count_q <= count_d;
                    valid_q <= (count_d != 2'd0);
                    ready_q <= (count_d != 2'd2);
                end
            end

            // main feeds the output, skid takes the second entry.
            always_ff @(posedge aclk) begin
                if (push && (count_q == 2'd0 || pop)) begin
                    main_q <= in_data;
                end else if (pop && count_q == 2'd2) begin
                    main_q <= skid_q;
                end
                if (push && !pop && count_q == 2'd1) begin
                    skid_q <= in_data;
                end
            end
        end
    endgenerate

endmodule : axi_channel_slice

// File: verilog/reset_pipe.sv
`timescale 1ns/1ps

module reset_pipe #(
    parameter int STAGES = 1
) (
    input  logic aclk,
    input  logic rst_n,
    output logic rst_out
);

    generate
        if (STAGES == 0) begin : g_wire
            assign rst_out = rst_n;

        end else begin : g_chain
            logic [STAGES-1:0] chain_q;

            // assert at once, release after STAGES edges.
            always_ff @(posedge aclk or negedge rst_n) begin
                if (!rst_n) begin
                    chain_q <= '0;
                end else begin
                    chain_q[0] <= 1'b1;
                    for (int i = 1; i < STAGES; i++) begin
                        chain_q[i] <= chain_q[i-1];
                    end
                end
            end

            assign rst_out = chain_q[STAGES-1];
        end
    endgenerate

endmodule : reset_pipe

// File: verilog/axi3_reg_slice.sv
`timescale 1ns/1ps

module axi3_reg_slice
    import axi3_pkg::*;
#(
    parameter int                ADDR_WID      = 32,
    parameter int                DATA_BYTE_WID = 4,
    parameter int                ID_WID        = 4,
    parameter int                USER_WID      = 1,
    parameter reg_slice_config_t CONFIG        = SLICE_FULL
) (
    input  logic                       aclk,
    input  logic                       rst_n,

    input  logic [ID_WID-1:0]          s_axi_awid,
    input  logic [ADDR_WID-1:0]        s_axi_awaddr,
    input  logic [AXI3_LEN_WID-1:0]    s_axi_awlen,
    input  logic [AXI3_SIZE_WID-1:0]   s_axi_awsize,
    input  logic [AXI3_BURST_WID-1:0]  s_axi_awburst,
    input  logic [AXI3_LOCK_WID-1:0]   s_axi_awlock,
    input  logic [AXI3_CACHE_WID-1:0]  s_axi_awcache,
    input  logic [AXI3_PROT_WID-1:0]   s_axi_awprot,
    input  logic [AXI3_REGION_WID-1:0] s_axi_awregion,
    input  logic [AXI3_QOS_WID-1:0]    s_axi_awqos,
    input  logic [USER_WID-1:0]        s_axi_awuser,
    input  logic                       s_axi_awvalid,
    output logic                       s_axi_awready,
    input  logic [ID_WID-1:0]          s_axi_wid,
    input  logic [DATA_BYTE_WID*8-1:0] s_axi_wdata,
    input  logic [DATA_BYTE_WID-1:0]   s_axi_wstrb,
    input  logic                       s_axi_wlast,
    input  logic [USER_WID-1:0]        s_axi_wuser,
    input  logic                       s_axi_wvalid,
    output logic                       s_axi_wready,
    output logic [ID_WID-1:0]          s_axi_bid,
    output logic [AXI3_RESP_WID-1:0]   s_axi_bresp,
    output logic [USER_WID-1:0]        s_axi_buser,
    output logic                       s_axi_bvalid,
    input  logic                       s_axi_bready,
    input  logic [ID_WID-1:0]          s_axi_arid,
    input  logic [ADDR_WID-1:0]        s_axi_araddr,
    input  logic [AXI3_LEN_WID-1:0]    s_axi_arlen,
    input  logic [AXI3_SIZE_WID-1:0]   s_axi_arsize,
    input  logic [AXI3_BURST_WID-1:0]  s_axi_arburst,
    input  logic [AXI3_LOCK_WID-1:0]   s_axi_arlock,
    input  logic [AXI3_CACHE_WID-1:0]  s_axi_arcache,
    input  logic [AXI3_PROT_WID-1:0]   s_axi_arprot,
    input  logic [AXI3_REGION_WID-1:0] s_axi_arregion,
    input  logic [AXI3_QOS_WID-1:0]    s_axi_arqos,
    input  logic [USER_WID-1:0]        s_axi_aruser,
    input  logic                       s_axi_arvalid,
    output logic                       s_axi_arready,
    output logic [ID_WID-1:0]          s_axi_rid,
    output logic [DATA_BYTE_WID*8-1:0] s_axi_rdata,
    output logic [AXI3_RESP_WID-1:0]   s_axi_rresp,
    output logic                       s_axi_rlast,
    output logic [USER_WID-1:0]        s_axi_ruser,
    output logic                       s_axi_rvalid,
    input  logic                       s_axi_rready,

    output logic [ID_WID-1:0]          m_axi_awid,
    output logic [ADDR_WID-1:0]        m_axi_awaddr,
    output logic [AXI3_LEN_WID-1:0]    m_axi_awlen,
    output logic [AXI3_SIZE_WID-1:0]   m_axi_awsize,
    output logic [AXI3_BURST_WID-1:0]  m_axi_awburst,
    output logic [AXI3_LOCK_WID-1:0]   m_axi_awlock,
    output logic [AXI3_CACHE_WID-1:0]  m_axi_awcache,
    output logic [AXI3_PROT_WID-1:0]   m_axi_awprot,
    output logic [AXI3_REGION_WID-1:0] m_axi_awregion,
    output logic [AXI3_QOS_WID-1:0]    m_axi_awqos,
    output logic [USER_WID-1:0]        m_axi_awuser,
    output logic                       m_axi_awvalid,
    input  logic                       m_axi_awready,
    output logic [ID_WID-1:0]          m_axi_wid,
    output logic [DATA_BYTE_WID*8-1:0] m_axi_wdata,
    output logic [DATA_BYTE_WID-1:0]   m_axi_wstrb,
    output logic                       m_axi_wlast,
    output logic [USER_WID-1:0]        m_axi_wuser,
    output logic                       m_axi_wvalid,
    input  logic                       m_axi_wready,
    input  logic [ID_WID-1:0]          m_axi_bid,
    input  logic [AXI3_RESP_WID-1:0]   m_axi_bresp,
    input  logic [USER_WID-1:0]        m_axi_buser,
    input  logic                       m_axi_bvalid,
    output logic                       m_axi_bready,
    output logic [ID_WID-1:0]          m_axi_arid,
    output logic [ADDR_WID-1:0]        m_axi_araddr,
    output logic [AXI3_LEN_WID-1:0]    m_axi_arlen,
    output logic [AXI3_SIZE_WID-1:0]   m_axi_arsize,
    output logic [AXI3_BURST_WID-1:0]  m_axi_arburst,
    output logic [AXI3_LOCK_WID-1:0]   m_axi_arlock,
    output logic [AXI3_CACHE_WID-1:0]  m_axi_arcache,
    output logic [AXI3_PROT_WID-1:0]   m_axi_arprot,
    output logic [AXI3_REGION_WID-1:0] m_axi_arregion,
    output logic [AXI3_QOS_WID-1:0]    m_axi_arqos,
    output logic [USER_WID-1:0]        m_axi_aruser,
    output logic                       m_axi_arvalid,
    input  logic                       m_axi_arready,
    input  logic [ID_WID-1:0]          m_axi_rid,
    input  logic [DATA_BYTE_WID*8-1:0] m_axi_rdata,
    input  logic [AXI3_RESP_WID-1:0]   m_axi_rresp,
    input  logic                       m_axi_rlast,
    input  logic [USER_WID-1:0]        m_axi_ruser,
    input  logic                       m_axi_rvalid,
    output logic                       m_axi_rready,

    output logic                       m_rst_n
);

    localparam int DATA_WID = DATA_BYTE_WID * 8;

    // payload widths, in packing order.
    localparam int ADDR_CH_WID = ID_WID + ADDR_WID + AXI3_LEN_WID + AXI3_SIZE_WID
                               + AXI3_BURST_WID + AXI3_LOCK_WID + AXI3_CACHE_WID
                               + AXI3_PROT_WID + AXI3_REGION_WID + AXI3_QOS_WID + USER_WID;
    localparam int W_CH_WID = ID_WID + DATA_WID + DATA_BYTE_WID + 1 + USER_WID;
    localparam int B_CH_WID = ID_WID + AXI3_RESP_WID + USER_WID;
    localparam int R_CH_WID = ID_WID + DATA_WID + AXI3_RESP_WID + 1 + USER_WID;

    logic [ADDR_CH_WID-1:0] aw_in;
    logic [ADDR_CH_WID-1:0] aw_out;
    logic [W_CH_WID-1:0]    w_in;
    logic [W_CH_WID-1:0]    w_out;
    logic [B_CH_WID-1:0]    b_in;
    logic [B_CH_WID-1:0]    b_out;
    logic [ADDR_CH_WID-1:0] ar_in;
    logic [ADDR_CH_WID-1:0] ar_out;
    logic [R_CH_WID-1:0]    r_in;
    logic [R_CH_WID-1:0]    r_out;

    // controller to peripheral.
    assign aw_in = {s_axi_awid, s_axi_awaddr, s_axi_awlen, s_axi_awsize, s_axi_awburst,
                    s_axi_awlock, s_axi_awcache, s_axi_awprot, s_axi_awregion,
                    s_axi_awqos, s_axi_awuser};
    assign {m_axi_awid, m_axi_awaddr, m_axi_awlen, m_axi_awsize, m_axi_awburst,
            m_axi_awlock, m_axi_awcache, m_axi_awprot, m_axi_awregion,
            m_axi_awqos, m_axi_awuser} = aw_out;

    assign w_in = {s_axi_wid, s_axi_wdata, s_axi_wstrb, s_axi_wlast, s_axi_wuser};
    assign {m_axi_wid, m_axi_wdata, m_axi_wstrb, m_axi_wlast, m_axi_wuser} = w_out;

    assign ar_in = {s_axi_arid, s_axi_araddr, s_axi_arlen, s_axi_arsize, s_axi_arburst,
                    s_axi_arlock, s_axi_arcache, s_axi_arprot, s_axi_arregion,
                    s_axi_arqos, s_axi_aruser};
    assign {m_axi_arid, m_axi_araddr, m_axi_arlen, m_axi_arsize, m_axi_arburst,
            m_axi_arlock, m_axi_arcache, m_axi_arprot, m_axi_arregion,
            m_axi_arqos, m_axi_aruser} = ar_out;

    // peripheral to controller.
    assign b_in = {m_axi_bid, m_axi_bresp, m_axi_buser};
    assign {s_axi_bid, s_axi_bresp, s_axi_buser} = b_out;

    assign r_in = {m_axi_rid, m_axi_rdata, m_axi_rresp, m_axi_rlast, m_axi_ruser};
    assign {s_axi_rid, s_axi_rdata, s_axi_rresp, s_axi_rlast, s_axi_ruser} = r_out;

    axi_channel_slice #(
        .PAYLOAD_WID ( ADDR_CH_WID ),
        .CONFIG      ( CONFIG )
    ) u_aw (
        .aclk      ( aclk ),
        .rst_n     ( rst_n ),
        .in_valid  ( s_axi_awvalid ),
        .in_ready  ( s_axi_awready ),
        .in_data   ( aw_in ),
        .out_valid ( m_axi_awvalid ),
        .out_ready ( m_axi_awready ),
        .out_data  ( aw_out )
    );

    axi_channel_slice #(
        .PAYLOAD_WID ( W_CH_WID ),
        .CONFIG      ( CONFIG )
    ) u_w (
        .aclk      ( aclk ),
        .rst_n     ( rst_n ),
        .in_valid  ( s_axi_wvalid ),
        .in_ready  ( s_axi_wready ),
        .in_data   ( w_in ),
        .out_valid ( m_axi_wvalid ),
        .out_ready ( m_axi_wready ),
        .out_data  ( w_out )
    );

    axi_channel_slice #(
        .PAYLOAD_WID ( B_CH_WID ),
        .CONFIG      ( CONFIG )
    ) u_b (
        .aclk      ( aclk ),
        .rst_n     ( rst_n ),
        .in_valid  ( m_axi_bvalid ),
        .in_ready  ( m_axi_bready ),
        .in_data   ( b_in ),
        .out_valid ( s_axi_bvalid ),
        .out_ready ( s_axi_bready ),
        .out_data  ( b_out )
    );

    axi_channel_slice #(
        .PAYLOAD_WID ( ADDR_CH_WID ),
        .CONFIG      ( CONFIG )
    ) u_ar (
        .aclk      ( aclk ),
        .rst_n     ( rst_n ),
        .in_valid  ( s_axi_arvalid ),
        .in_ready  ( s_axi_arready ),
        .in_data   ( ar_in ),
        .out_valid ( m_axi_arvalid ),
        .out_ready ( m_axi_arready ),
        .out_data  ( ar_out )
    );

    axi_channel_slice #(
        .PAYLOAD_WID ( R_CH_WID ),
        .CONFIG      ( CONFIG )
    ) u_r (
        .aclk      ( aclk ),
        .rst_n     ( rst_n ),
        .in_valid  ( m_axi_rvalid ),
        .in_ready  ( m_axi_rready ),
        .in_data   ( r_in ),
        .out_valid ( s_axi_rvalid ),
        .out_ready ( s_axi_rready ),
        .out_data  ( r_out )
    );

    // peripheral leaves reset once the stages are ready.
    reset_pipe #(
        .STAGES ( reset_pipe_stages(CONFIG) )
    ) u_rst (
        .aclk    ( aclk ),
        .rst_n   ( rst_n ),
        .rst_out ( m_rst_n )
    );

endmodule : axi3_reg_slice

// File: verification/clock_gen.sv
`timescale 1ns/1ps

module clock_gen #(
    parameter int PERIOD_NS = 20
) (
    output logic clk
);

    // free-running, starts low.
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule : clock_gen

// File: verification/axi3_reg_slice_tb.sv
`timescale 1ns/1ps

module axi3_reg_slice_tb
    import axi3_pkg::*;
();

    localparam int STALL_NONE   = 0;
    localparam int STALL_RANDOM = 1;
    localparam int STALL_HOLD   = 2;

    // full mode holds the peripheral in reset for one edge.
    localparam int RST_RELEASE_EDGES = 1;

    // channels are indexed aw, w, b, ar, r from 0.
    typedef struct {
        int          test;
        int          ch;
        logic [3:0]  id;
        logic [31:0] data;
        logic [31:0] aux;
        logic        last;
        logic        user;
        int          stall;
        int          k;
    } entry_t;

    logic aclk;
    logic rst_n;
    logic m_rst_n;
    logic [3:0]  s_axi_awid, s_axi_arid, s_axi_wid, s_axi_bid, s_axi_rid;
    logic [3:0]  m_axi_awid, m_axi_arid, m_axi_wid, m_axi_bid, m_axi_rid;
    logic [31:0] s_axi_awaddr, s_axi_araddr, m_axi_awaddr, m_axi_araddr;
    logic [31:0] s_axi_wdata, s_axi_rdata, m_axi_wdata, m_axi_rdata;
    logic [AXI3_LEN_WID-1:0]    s_axi_awlen, s_axi_arlen, m_axi_awlen, m_axi_arlen;
    logic [AXI3_SIZE_WID-1:0]   s_axi_awsize, s_axi_arsize, m_axi_awsize, m_axi_arsize;
    logic [AXI3_BURST_WID-1:0]  s_axi_awburst, s_axi_arburst, m_axi_awburst, m_axi_arburst;
    logic [AXI3_LOCK_WID-1:0]   s_axi_awlock, s_axi_arlock, m_axi_awlock, m_axi_arlock;
    logic [AXI3_CACHE_WID-1:0]  s_axi_awcache, s_axi_arcache, m_axi_awcache, m_axi_arcache;
    logic [AXI3_PROT_WID-1:0]   s_axi_awprot, s_axi_arprot, m_axi_awprot, m_axi_arprot;
    logic [AXI3_REGION_WID-1:0] s_axi_awregion, s_axi_arregion, m_axi_awregion, m_axi_arregion;
    logic [AXI3_QOS_WID-1:0]    s_axi_awqos, s_axi_arqos, m_axi_awqos, m_axi_arqos;
    logic [0:0]  s_axi_awuser, s_axi_aruser, s_axi_wuser, s_axi_buser, s_axi_ruser;
    logic [0:0]  m_axi_awuser, m_axi_aruser, m_axi_wuser, m_axi_buser, m_axi_ruser;
    logic [3:0]  s_axi_wstrb, m_axi_wstrb;
    logic [AXI3_RESP_WID-1:0]   s_axi_bresp, s_axi_rresp, m_axi_bresp, m_axi_rresp;
    logic        s_axi_wlast, s_axi_rlast, m_axi_wlast, m_axi_rlast;
    logic        s_axi_awvalid, s_axi_wvalid, m_axi_bvalid, s_axi_arvalid, m_axi_rvalid;
    logic        s_axi_awready, s_axi_wready, m_axi_bready, s_axi_arready, m_axi_rready;
    logic        m_axi_awvalid, m_axi_wvalid, s_axi_bvalid, m_axi_arvalid, s_axi_rvalid;
    logic        m_axi_awready, m_axi_wready, s_axi_bready, m_axi_arready, s_axi_rready;

    logic [4:0] src_valid;
    logic [4:0] dst_ready;
    wire  [4:0] src_ready = {m_axi_rready, s_axi_arready, m_axi_bready, s_axi_wready,
                             s_axi_awready};
    wire  [4:0] dst_valid = {s_axi_rvalid, m_axi_arvalid, s_axi_bvalid, m_axi_wvalid,
                             m_axi_awvalid};

    assign {m_axi_rvalid, s_axi_arvalid, m_axi_bvalid, s_axi_wvalid, s_axi_awvalid} = src_valid;
    assign {s_axi_rready, m_axi_arready, s_axi_bready, m_axi_wready, m_axi_awready} = dst_ready;

    entry_t table_q[$];
    entry_t send_q[5][$];
    entry_t exp_q[5][$];
    int     in_cyc[5][$];
    int     stall_mode[5];
    int     stall_k[5];
    int     got[5];
    int     sent[5];
    string  ch_name[5] = '{"aw", "w", "b", "ar", "r"};
    string  test_name[5] = '{"w full-rate burst", "aw/ar payload", "b hold back-pressure",
                             "r/b random ready", "channel independence"};
    int     seed = 32'h9bf3_d445;
    int     cycle = 0;
    int     limit = 1000000;
    int     err_count = 0;
    int     check_count = 0;
    int     tests_run = 0;
    int     tests_failed = 0;

    clock_gen #(.PERIOD_NS(20)) u_clk (.clk(aclk));

    axi3_reg_slice #(.CONFIG(SLICE_FULL)) uut (.*);

    task automatic check_val(input string name, input logic [63:0] got_v,
                             input logic [63:0] exp_v);
        check_count++;
        assert (got_v === exp_v) else begin
            $display("ERR t=%0t %s expected %h got %h", $time, name, exp_v, got_v);
            err_count++;
        end
    endtask

    task automatic add_entry(input int test, input int ch, input logic [3:0] id,
                             input logic [31:0] data, input logic [31:0] aux,
                             input logic last, input int stall, input int k);
        entry_t e;
        e = '{test, ch, id, data, aux, last, id[0], stall, k};
        table_q.push_back(e);
    endtask

    task automatic set_fields(input int c, input entry_t e);
        case (c)
            0: begin
                {s_axi_awid, s_axi_awaddr, s_axi_awuser} = {e.id, e.data, e.user};
                {s_axi_awqos, s_axi_awregion, s_axi_awprot, s_axi_awcache, s_axi_awlock,
                 s_axi_awburst, s_axi_awsize, s_axi_awlen} = e.aux[25:0];
            end
            1: {s_axi_wid, s_axi_wdata, s_axi_wstrb, s_axi_wlast, s_axi_wuser} =
                   {e.id, e.data, e.aux[3:0], e.last, e.user};
            2: {m_axi_bid, m_axi_bresp, m_axi_buser} = {e.id, e.aux[1:0], e.user};
            3: begin
                {s_axi_arid, s_axi_araddr, s_axi_aruser} = {e.id, e.data, e.user};
                {s_axi_arqos, s_axi_arregion, s_axi_arprot, s_axi_arcache, s_axi_arlock,
                 s_axi_arburst, s_axi_arsize, s_axi_arlen} = e.aux[25:0];
            end
            default: {m_axi_rid, m_axi_rdata, m_axi_rresp, m_axi_rlast, m_axi_ruser} =
                         {e.id, e.data, e.aux[1:0], e.last, e.user};
        endcase
    endtask

    // aux holds len, size, burst, lock, cache, prot, region, qos from bit 0 up.
    task automatic compare_beat(input int c, input entry_t e);
        case (c)
            0: begin
                check_val("m_axi_awid", m_axi_awid, e.id);
                check_val("m_axi_awaddr", m_axi_awaddr, e.data);
                check_val("m_axi_awlen", m_axi_awlen, e.aux[3:0]);
                check_val("m_axi_awsize", m_axi_awsize, e.aux[6:4]);
                check_val("m_axi_awburst", m_axi_awburst, e.aux[8:7]);
                check_val("m_axi_awlock", m_axi_awlock, e.aux[10:9]);
                check_val("m_axi_awcache", m_axi_awcache, e.aux[14:11]);
                check_val("m_axi_awprot", m_axi_awprot, e.aux[17:15]);
                check_val("m_axi_awregion", m_axi_awregion, e.aux[21:18]);
                check_val("m_axi_awqos", m_axi_awqos, e.aux[25:22]);
                check_val("m_axi_awuser", m_axi_awuser, e.user);
            end
            1: begin
                check_val("m_axi_wid", m_axi_wid, e.id);
                check_val("m_axi_wdata", m_axi_wdata, e.data);
                check_val("m_axi_wstrb", m_axi_wstrb, e.aux[3:0]);
                check_val("m_axi_wlast", m_axi_wlast, e.last);
                check_val("m_axi_wuser", m_axi_wuser, e.user);
            end
            2: begin
                check_val("s_axi_bid", s_axi_bid, e.id);
                check_val("s_axi_bresp", s_axi_bresp, e.aux[1:0]);
                check_val("s_axi_buser", s_axi_buser, e.user);
            end
            3: begin
                check_val("m_axi_arid", m_axi_arid, e.id);
                check_val("m_axi_araddr", m_axi_araddr, e.data);
                check_val("m_axi_arlen", m_axi_arlen, e.aux[3:0]);
                check_val("m_axi_arsize", m_axi_arsize, e.aux[6:4]);
                check_val("m_axi_arburst", m_axi_arburst, e.aux[8:7]);
                check_val("m_axi_arlock", m_axi_arlock, e.aux[10:9]);
                check_val("m_axi_arcache", m_axi_arcache, e.aux[14:11]);
                check_val("m_axi_arprot", m_axi_arprot, e.aux[17:15]);
                check_val("m_axi_arregion", m_axi_arregion, e.aux[21:18]);
                check_val("m_axi_arqos", m_axi_arqos, e.aux[25:22]);
                check_val("m_axi_aruser", m_axi_aruser, e.user);
            end
            default: begin
                check_val("s_axi_rid", s_axi_rid, e.id);
                check_val("s_axi_rdata", s_axi_rdata, e.data);
                check_val("s_axi_rresp", s_axi_rresp, e.aux[1:0]);
                check_val("s_axi_rlast", s_axi_rlast, e.last);
                check_val("s_axi_ruser", s_axi_ruser, e.user);
            end
        endcase
    endtask

    // source side of one channel; records each accepted beat.
    task automatic drive_channel(input int c);
        int accepted;
        bit seen_low;
        accepted = 0;
        seen_low = 0;
        for (int i = 0; i < send_q[c].size(); i++) begin
            @(negedge aclk);
            set_fields(c, send_q[c][i]);
            src_valid[c] = 1'b1;
            @(posedge aclk);
            while (!src_ready[c]) begin
                if (stall_mode[c] == STALL_HOLD && !seen_low) begin
                    seen_low = 1;
                    check_val({ch_name[c], " beats before in_ready low"}, accepted, 2);
                end
                @(posedge aclk);
            end
            accepted++;
            exp_q[c].push_back(send_q[c][i]);
            in_cyc[c].push_back(cycle);
        end
        // more beats than entries under a held stall must see in_ready fall.
        if (stall_mode[c] == STALL_HOLD && send_q[c].size() > 2) begin
            assert (seen_low) else begin
                $display("channel %s kept in_ready high under back-pressure", ch_name[c]);
                err_count++;
            end
        end
        @(negedge aclk);
        src_valid[c] = 1'b0;
    endtask

    // sink ready of one channel until every beat has come out.
    task automatic drive_ready(input int c);
        int n;
        n = 0;
        while (got[c] < sent[c]) begin
            @(negedge aclk);
            case (stall_mode[c])
                STALL_RANDOM: dst_ready[c] = $random(seed) & 1;
                STALL_HOLD:   dst_ready[c] = (n >= stall_k[c]);
                default:      dst_ready[c] = 1'b1;
            endcase
            n++;
        end
    endtask

    task automatic run_test(input int t);
        int err_before;
        err_before = err_count;
        for (int c = 0; c < 5; c++) begin
            sent[c] = send_q[c].size();
            got[c] = 0;
        end
        fork
            drive_channel(0);
            drive_channel(1);
            drive_channel(2);
            drive_channel(3);
            drive_channel(4);
            drive_ready(0);
            drive_ready(1);
            drive_ready(2);
            drive_ready(3);
            drive_ready(4);
        join
        for (int c = 0; c < 5; c++) begin
            send_q[c].delete();
            stall_mode[c] = STALL_NONE;
        end
        repeat (2) @(negedge aclk);
        tests_run++;
        if (err_count != err_before) begin
            tests_failed++;
        end
        $display("test %0d %s: %s", t, test_name[t], (err_count == err_before) ? "ok" : "bad");
    endtask

    // output monitor and scoreboard.
    always @(posedge aclk) begin
        if (!rst_n) begin
            check_val("output valids in reset", dst_valid, 5'b0);
            check_val("m_rst_n in reset", m_rst_n, 1'b0);
        end else begin
            for (int c = 0; c < 5; c++) begin
                if (dst_valid[c] && dst_ready[c]) begin
                    assert (exp_q[c].size() != 0) else begin
                        $display("unexpected beat on channel %s at %0t", ch_name[c], $time);
                        err_count++;
                    end
                    if (exp_q[c].size() != 0) begin
                        compare_beat(c, exp_q[c].pop_front());
                        if (stall_mode[c] == STALL_NONE) begin
                            check_val({ch_name[c], " latency"}, cycle - in_cyc[c][0], 1);
                        end
                        void'(in_cyc[c].pop_front());
                        got[c]++;
                    end
                end
            end
        end
    end

    always @(negedge aclk) begin
        cycle++;
        if (cycle >= limit) begin
            $display("timeout: run stopped after %0d cycles without finishing", cycle);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        int edges;
        int budget;
        rst_n = 1'b0;
        src_valid = '0;
        dst_ready = '0;
        for (int c = 0; c < 5; c++) begin
            set_fields(c, '{0, c, 4'h0, 32'h0, 32'h0, 1'b0, 1'b0, 0, 0});
            stall_mode[c] = STALL_NONE;
        end

        add_entry(0, 1, 4'h1, 32'h1111_0001, 32'hf, 1'b0, STALL_NONE, 0);
        add_entry(0, 1, 4'h1, 32'h2222_0002, 32'h3, 1'b0, STALL_NONE, 0);
        add_entry(0, 1, 4'h1, 32'h3333_0003, 32'h8, 1'b1, STALL_NONE, 0);
        add_entry(1, 0, 4'h5, 32'h8000_1000, 32'h02a5_4a13, 1'b0, STALL_NONE, 0);
        add_entry(1, 3, 4'ha, 32'h4000_2040, 32'h0153_b5ec, 1'b0, STALL_NONE, 0);
        add_entry(2, 2, 4'h3, 32'h0, AXI3_RESP_OKAY, 1'b0, STALL_HOLD, 5);
        add_entry(2, 2, 4'h6, 32'h0, AXI3_RESP_SLVERR, 1'b0, STALL_HOLD, 5);
        add_entry(2, 2, 4'h9, 32'h0, AXI3_RESP_OKAY, 1'b0, STALL_HOLD, 5);
        add_entry(3, 4, 4'h2, 32'hdead_beef, AXI3_RESP_OKAY, 1'b0, STALL_RANDOM, 4);
        add_entry(3, 4, 4'h2, 32'hcafe_f00d, AXI3_RESP_SLVERR, 1'b0, STALL_RANDOM, 4);
        add_entry(3, 4, 4'h2, 32'h0bad_cafe, AXI3_RESP_OKAY, 1'b1, STALL_RANDOM, 4);
        add_entry(3, 2, 4'hc, 32'h0, AXI3_RESP_SLVERR, 1'b0, STALL_RANDOM, 4);
        add_entry(3, 2, 4'hd, 32'h0, AXI3_RESP_OKAY, 1'b0, STALL_RANDOM, 4);
        add_entry(4, 2, 4'h7, 32'h0, AXI3_RESP_OKAY, 1'b0, STALL_HOLD, 8);
        add_entry(4, 2, 4'h8, 32'h0, AXI3_RESP_SLVERR, 1'b0, STALL_HOLD, 8);
        add_entry(4, 2, 4'hb, 32'h0, AXI3_RESP_OKAY, 1'b0, STALL_HOLD, 8);
        add_entry(4, 0, 4'he, 32'h1234_5678, 32'h03ff_ffff, 1'b0, STALL_NONE, 0);
        add_entry(4, 1, 4'he, 32'h5a5a_a5a5, 32'h5, 1'b0, STALL_NONE, 0);
        add_entry(4, 1, 4'he, 32'ha5a5_5a5a, 32'ha, 1'b1, STALL_NONE, 0);
        add_entry(4, 3, 4'h4, 32'h9abc_def0, 32'h0, 1'b0, STALL_NONE, 0);

        // one beat per entry, one stall per channel of a test.
        budget = 0;
        foreach (table_q[i]) begin
            budget += 1;
            if (i == 0 || table_q[i - 1].test != table_q[i].test
                    || table_q[i - 1].ch != table_q[i].ch) begin
                budget += table_q[i].k;
            end
        end
        limit = budget * 4 + 100;

        repeat (3) @(posedge aclk);
        @(negedge aclk);
        rst_n = 1'b1;
        // sampled just before the first edge after release.
        @(posedge aclk);
        check_val("m_rst_n before first edge", m_rst_n, 1'b0);
        check_val("input readys after reset", src_ready, 5'h1f);
        edges = 1;
        @(negedge aclk);
        check_val("output valids after reset", dst_valid, 5'b0);
        while (!m_rst_n && edges < 8) begin
            @(negedge aclk);
            edges++;
        end
        check_val("reset_pipe_stages full", reset_pipe_stages(SLICE_FULL), RST_RELEASE_EDGES);
        check_val("m_rst_n release edges", edges, RST_RELEASE_EDGES);
        tests_run++;
        if (err_count != 0) begin
            tests_failed++;
        end
        $display("test reset: %s", (err_count == 0) ? "ok" : "bad");

        for (int i = 0; i < table_q.size(); i++) begin
            send_q[table_q[i].ch].push_back(table_q[i]);
            stall_mode[table_q[i].ch] = table_q[i].stall;
            stall_k[table_q[i].ch] = table_q[i].k;
            if (i == table_q.size() - 1 || table_q[i + 1].test != table_q[i].test) begin
                run_test(table_q[i].test);
            end
        end

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_count, err_count);
        if (err_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule : axi3_reg_slice_tb

// File: sources.f
verilog/axi3_pkg.sv
verilog/axi_channel_slice.sv
verilog/reset_pipe.sv
verilog/axi3_reg_slice.sv
verification/clock_gen.sv
verification/axi3_reg_slice_tb.sv

// File: Makefile
TOP = axi3_reg_slice_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f sources.f -o sim

run: compile
	./obj_dir/sim | tee sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
